// File: files.f
rtl/adc_pkg.sv
rtl/sclk_gen.sv
rtl/command_shifter.sv
rtl/result_capture.sv
rtl/scan_sequencer.sv
rtl/ltc_adc_scanner.sv
tests/tb_clock.sv
tests/ltc2308_model.sv
tests/tb_ltc_adc_scanner.sv

// File: run.sh
#!/bin/sh
# Compiles the scanner testbench with Verilator, runs it and checks the result.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
        -f files.f --top-module tb_ltc_adc_scanner -Mdir obj_dir -o sim
status=$?
if [ $status -ne 0 ]; then
        echo "Verilator build failed with status $status"
        exit 1
fi

output=$(./obj_dir/sim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
        echo "Simulation exited with status $status"
        exit 1
fi

if printf '%s\n' "$output" | grep -qx "TEST PASS"; then
        exit 0
else
        echo "Pass message not found in simulation output"
        exit 1
fi

// File: tests/tb_ltc_adc_scanner.sv
// Testbench for the LTC2308 scanning controller.
// Runs two scans against the ADC model with random tables, checks the SCLK and
// cs_n timing, the command order, the bank of readings and the done level.

`timescale 1ns/1ps
`default_nettype none

module tb_ltc_adc_scanner;

        localparam int clk_period  = 20;
        localparam int t_sclk      = 4;
        localparam int num_ch      = 5;
        localparam int half        = t_sclk / 2;
        localparam int quiet_min   = adc_pkg::QUIET_PERIODS * t_sclk;
        localparam int scan_cycles = 7 * (adc_pkg::FRAME_BITS + adc_pkg::QUIET_PERIODS) * t_sclk;
        localparam int done_limit  = 2 * scan_cycles;
        localparam int watchdog_cycles = 3 * 2 * scan_cycles;

        logic               clock;
        logic               reset;
        logic               go;
        logic               dout;
        logic               sclk;
        logic               cs_n;
        logic               din;
        logic               done;
        adc_pkg::readings_t readings;
        adc_pkg::readings_t table_vals;
        adc_pkg::chan_t     model_chan;
        adc_pkg::chan_t     expect_order[$];
        int                 model_errors;
        int                 errors;
        int                 seed;
        logic               prev_sclk;
        logic               prev_cs_n;
        logic               seen_frame;
        int                 run_len;
        int                 quiet_len;

        tb_clock #(.period(clk_period), .reset_cycles(2)) clock0 (.clock(clock), .reset(reset));

        ltc_adc_scanner #(
                .t_sclk (t_sclk),
                .num_ch (num_ch)
        ) dut0 (
                .clock    (clock),
                .reset    (reset),
                .go       (go),
                .dout     (dout),
                .sclk     (sclk),
                .cs_n     (cs_n),
                .din      (din),
                .done     (done),
                .readings (readings)
        );

        ltc2308_model model0 (
                .sclk   (sclk),
                .cs_n   (cs_n),
                .din    (din),
                .values (table_vals),
                .dout   (dout),
                .chan   (model_chan),
                .errors (model_errors)
        );

        task automatic log_failure(input string msg);
                $display("FAILED at %0t: %s", $time, msg);
                errors++;
        endtask

        task automatic check_bank();
                int               c;
                adc_pkg::sample_t expected;
                for (c = 0; c < 8; c++)
                begin
                        expected = (c <= num_ch) ? table_vals[c] : '0;
                        assert (readings[c] == expected)
                        else log_failure($sformatf("reading %0d is %h, expected %h",
                                                   c, readings[c], expected));
                end
        endtask

        task automatic run_scan();
                int c;
                int waited;
                for (c = 0; c < 8; c++)
                        table_vals[c] = 12'($random(seed));
                // Set-up frame commands the top channel, then the scan counts up
                expect_order.push_back(adc_pkg::chan_t'(num_ch));
                for (c = 0; c <= num_ch; c++)
                        expect_order.push_back(adc_pkg::chan_t'(c));
                go     = 1'b1;
                waited = 0;
                while (!done && waited < done_limit)
                begin
                        @(negedge clock);
                        waited++;
                end
                if (!done)
                begin
                        $display("done did not rise within %0d cycles of go", done_limit);
                        errors++;
                end
                else
                begin
                        check_bank();
                        assert (expect_order.size() == 0)
                        else log_failure("scan ended before all frames were seen");
                end
                repeat (10)
                begin
                        @(negedge clock);
                        assert (done) else log_failure("done fell while go was high");
                end
                go = 1'b0;
                @(negedge clock);
                assert (!done) else log_failure("done still high after go was released");
        endtask

        // SCLK phase lengths inside frames and quiet time between frames
        always @(negedge clock)
        begin
                if (reset)
                begin
                        prev_sclk  = 1'b0;
                        prev_cs_n  = 1'b1;
                        seen_frame = 1'b0;
                        run_len    = 0;
                        quiet_len  = 0;
                end
                else
                begin
                        if (!cs_n && prev_cs_n)
                        begin
                                if (seen_frame)
                                        assert (quiet_len >= quiet_min)
                                        else log_failure($sformatf("quiet time %0d cycles",
                                                                   quiet_len));
                                run_len = 1;
                        end
                        else if (!cs_n)
                        begin
                                if (sclk != prev_sclk)
                                begin
                                        assert (run_len == half)
                                        else log_failure($sformatf("SCLK phase %0d cycles",
                                                                   run_len));
                                        run_len = 1;
                                end
                                else
                                        run_len++;
                        end
                        else if (!prev_cs_n)
                        begin
                                assert (run_len == half)
                                else log_failure($sformatf("last SCLK phase %0d cycles", run_len));
                                seen_frame = 1'b1;
                                quiet_len  = 1;
                        end
                        else
                                quiet_len++;
                        prev_sclk = sclk;
                        prev_cs_n = cs_n;
                end
        end

        // The model decodes the channel at each frame end
        always
        begin
                @(negedge cs_n);
                @(posedge cs_n);
                @(negedge clock);
                if (expect_order.size() == 0)
                        log_failure("frame seen outside of a scan");
                else
                        assert (model_chan == expect_order[0])
                        else log_failure($sformatf("frame decoded channel %0d, expected %0d",
                                                   model_chan, expect_order[0]));
                if (expect_order.size() != 0)
                        void'(expect_order.pop_front());
        end

        initial
        begin
                repeat (watchdog_cycles) @(posedge clock);
                $display("Watchdog expired after %0d clock cycles", watchdog_cycles);
                $display("TEST FAIL");
                $finish;
        end

        initial
        begin
                seed       = 73;
                go         = 1'b0;
                errors     = 0;
                table_vals = '0;
                @(negedge reset);
                repeat (20)
                begin
                        @(negedge clock);
                        assert (cs_n && !sclk && !done && readings == '0)
                        else log_failure("outputs not at rest while idle");
                end
                run_scan();
                repeat (5) @(negedge clock);
                run_scan();
                $display("Errors: testbench %0d, model %0d", errors, model_errors);
                if (errors + model_errors == 0)
                        $display("TEST PASS");
                else
                        $display("TEST FAIL");
                $finish;
        end

endmodule

`default_nettype wire

// File: tests/ltc2308_model.sv
// Behavioral model of an LTC2308-style serial ADC for the testbench.
// Decodes the command on DIN, checks each frame, and returns on DOUT the table
// value of the channel that the previous frame selected.

`timescale 1ns/1ps
`default_nettype none

module ltc2308_model (
        input  logic               sclk,
        input  logic               cs_n,
        input  logic               din,
        input  adc_pkg::readings_t values,
        output logic               dout,
        output adc_pkg::chan_t     chan,
        output int                 errors
);

        adc_pkg::sample_t pending;
        adc_pkg::sample_t out_q;
        adc_pkg::ltc_cmd_t cmd_q;
        adc_pkg::chan_t   decoded;
        int               rises;
        logic             in_frame;

        initial
        begin
                pending  = '0;
                out_q    = '0;
                cmd_q    = '0;
                dout     = 1'b0;
                chan     = '0;
                errors   = 0;
                rises    = 0;
                in_frame = 1'b0;
        end

        // The result of the last conversion goes out MSB first as soon as the frame opens
        always @(negedge cs_n)
        begin
                in_frame = 1'b1;
                rises    = 0;
                out_q    = pending;
                dout     = pending[11];
        end

        always @(posedge sclk)
        begin
                if (in_frame)
                begin
                        if (rises < $bits(adc_pkg::ltc_cmd_t))
                                cmd_q = {cmd_q[4:0], din};
                        else
                                assert (din == 1'b0)
                                else begin
                                        $display("FAILED at %0t: DIN is 1 after the command bits",
                                                 $time);
                                        errors++;
                                end
                        rises = rises + 1;
                end
        end

        always @(negedge sclk)
        begin
                if (in_frame)
                begin
                        out_q = {out_q[10:0], 1'b0};
                        dout  = out_q[11];
                end
        end

        // Frame end starts the conversion of the channel just commanded
        always @(posedge cs_n)
        begin
                if (in_frame)
                begin
                        in_frame = 1'b0;
                        assert (rises == adc_pkg::FRAME_BITS)
                        else begin
                                $display("FAILED at %0t: frame had %0d SCLK rises, expected %0d",
                                         $time, rises, adc_pkg::FRAME_BITS);
                                errors++;
                        end
                        assert (cmd_q.single_ended && cmd_q.unipolar && !cmd_q.sleep)
                        else begin
                                $display("FAILED at %0t: bad command word %b", $time, cmd_q);
                                errors++;
                        end
                        // Address bits arrive as O/S, S1, S0
                        decoded = {cmd_q.sel1, cmd_q.sel0, cmd_q.odd_sign};
                        chan    = decoded;
                        pending = values[decoded];
                end
        end

endmodule

`default_nettype wire

// File: tests/tb_clock.sv
// Clock and reset source for the scanner testbench.
// Produces a free-running clock of the given period and holds reset high
// for a number of clock cycles, releasing it on a falling edge.

`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
        parameter int period       = 20,
        parameter int reset_cycles = 2
) (
        output logic clock,
        output logic reset
);

        initial
        begin
                clock = 1'b0;
                reset = 1'b1;
                repeat (reset_cycles) @(negedge clock);
                reset = 1'b0;
        end

        always #(period / 2) clock = ~clock;

endmodule

`default_nettype wire

// File: rtl/ltc_adc_scanner.sv
// Top level of the LTC2308 scanning controller.
// Raise go to scan channels 0 to num_ch; done goes high once readings holds
// the new results and stays high until go is lowered. t_sclk is the SCLK
// period in clock cycles and must be even and at least 4.

`timescale 1ns/1ps
`default_nettype none

module ltc_adc_scanner #(
        parameter int t_sclk = 4,
        parameter int num_ch = 7
) (
        input  logic               clock,
        input  logic               reset,
        input  logic               go,
        input  logic               dout,
        output logic               sclk,
        output logic               cs_n,
        output logic               din,
        output logic               done,
        output adc_pkg::readings_t readings
);

        adc_pkg::sclk_tick_t tick;
        adc_pkg::chan_t      cmd_chan;
        adc_pkg::store_t     store;
        logic                cmd_load;

        sclk_gen #(
                .t_sclk (t_sclk)
        ) sclk_gen0 (
                .clock (clock),
                .reset (reset),
                .cs_n  (cs_n),
                .sclk  (sclk),
                .tick  (tick)
        );

        command_shifter command_shifter0 (
                .clock    (clock),
                .reset    (reset),
                .cmd_load (cmd_load),
                .cmd_chan (cmd_chan),
                .tick     (tick),
                .din      (din)
        );

        result_capture result_capture0 (
                .clock    (clock),
                .reset    (reset),
                .tick     (tick),
                .dout     (dout),
                .store    (store),
                .readings (readings)
        );

        scan_sequencer #(
                .t_sclk (t_sclk),
                .num_ch (num_ch)
        ) scan_sequencer0 (
                .clock    (clock),
                .reset    (reset),
                .go       (go),
                .tick     (tick),
                .cs_n     (cs_n),
                .done     (done),
                .cmd_load (cmd_load),
                .cmd_chan (cmd_chan),
                .store    (store)
        );

endmodule

`default_nettype wire

// File: rtl/scan_sequencer.sv
// Scan control for the ADC.
// After go it sends one set-up frame, then one frame per channel from 0 to num_ch,
// each followed by the quiet time. Because every frame returns the result of the
// previous command, results are stored one address behind the command.

`timescale 1ns/1ps
`default_nettype none

module scan_sequencer #(
        parameter int t_sclk = 4,
        parameter int num_ch = 7
) (
        input  logic                clock,
        input  logic                reset,
        input  logic                go,
        input  adc_pkg::sclk_tick_t tick,
        output logic                cs_n,
        output logic                done,
        output logic                cmd_load,
        output adc_pkg::chan_t      cmd_chan,
        output adc_pkg::store_t     store
);

        localparam int quiet_cycles = adc_pkg::QUIET_PERIODS * t_sclk;
        localparam int quiet_w      = $clog2(quiet_cycles);

        localparam logic [quiet_w-1:0] quiet_reload = quiet_w'(quiet_cycles - 1);
        localparam adc_pkg::chan_t     last_chan    = adc_pkg::chan_t'(num_ch);

        adc_pkg::scan_state_e state;
        adc_pkg::chan_t       addr;
        logic [quiet_w-1:0]   quiet_cnt;
        logic                 last_seen;
        logic                 frame_end;
        logic                 quiet_end;

        // A frame closes on the SCLK fall that follows its final rise
        assign frame_end = last_seen && tick.fall;
        assign quiet_end = (quiet_cnt == '0);

        assign done = (state == adc_pkg::st_done);

        assign store.write = (state == adc_pkg::st_frame);
        assign store.chan  = (addr == '0) ? last_chan : adc_pkg::chan_t'(addr - 1'b1);

        // The command is loaded in the same cycle that cs_n is driven low
        always_comb
        begin
                cmd_load = 1'b0;
                cmd_chan = adc_pkg::chan_t'(addr + 1'b1);
                case (state)
                        adc_pkg::st_idle:
                        begin
                                cmd_load = go;
                                cmd_chan = last_chan;
                        end
                        adc_pkg::st_init_quiet:
                        begin
                                cmd_load = quiet_end;
                                cmd_chan = '0;
                        end
                        adc_pkg::st_quiet:
                        begin
                                cmd_load = quiet_end && (addr != last_chan);
                        end
                        default:
                        begin
                                cmd_load = 1'b0;
                        end
                endcase
        end

        always_ff @(posedge clock or posedge reset)
        begin
                if (reset)
                begin
                        state     <= adc_pkg::st_idle;
                        cs_n      <= 1'b1;
                        addr      <= '0;
                        quiet_cnt <= '0;
                        last_seen <= 1'b0;
                end
                else
                begin
                        case (state)
                                adc_pkg::st_idle:
                                begin
                                        if (go)
                                        begin
                                                state     <= adc_pkg::st_init;
                                                cs_n      <= 1'b0;
                                                last_seen <= 1'b0;
                                        end
                                end
                                adc_pkg::st_init,
                                adc_pkg::st_frame:
                                begin
                                        if (tick.last)
                                                last_seen <= 1'b1;
                                        if (frame_end)
                                        begin
                                                cs_n      <= 1'b1;
                                                quiet_cnt <= quiet_reload;
                                                if (state == adc_pkg::st_init)
                                                        state <= adc_pkg::st_init_quiet;
                                                else
                                                        state <= adc_pkg::st_quiet;
                                        end
                                end
                                adc_pkg::st_init_quiet:
                                begin
                                        if (quiet_end)
                                        begin
                                                state     <= adc_pkg::st_frame;
                                                cs_n      <= 1'b0;
                                                last_seen <= 1'b0;
                                                addr      <= '0;
                                        end
                                        else
                                        begin
                                                quiet_cnt <= quiet_cnt - 1'b1;
                                        end
                                end
                                adc_pkg::st_quiet:
                                begin
                                        if (!quiet_end)
                                        begin
                                                quiet_cnt <= quiet_cnt - 1'b1;
                                        end
                                        else if (addr == last_chan)
                                        begin
                                                state <= adc_pkg::st_done;
                                        end
                                        else
                                        begin
                                                state     <= adc_pkg::st_frame;
                                                cs_n      <= 1'b0;
                                                last_seen <= 1'b0;
                                                addr      <= addr + 1'b1;
                                        end
                                end
                                adc_pkg::st_done:
                                begin
                                        // Hold the result until go is released
                                        if (!go)
                                                state <= adc_pkg::st_idle;
                                end
                                default:
                                begin
                                        state <= adc_pkg::st_idle;
                                        cs_n  <= 1'b1;
                                end
                        endcase
                end
        end

endmodule

`default_nettype wire

// File: rtl/result_capture.sv
// Receive path from the ADC DOUT pin.
// Shifts DOUT in at each SCLK rise and, on the final rise of a frame, writes the
// finished sample into the bank slot that the sequencer names on store.

`timescale 1ns/1ps
`default_nettype none

module result_capture (
        input  logic                clock,
        input  logic                reset,
        input  adc_pkg::sclk_tick_t tick,
        input  logic                dout,
        input  adc_pkg::store_t     store,
        output adc_pkg::readings_t  readings
);

        localparam int shift_bits = adc_pkg::FRAME_BITS - 1;

        logic [shift_bits-1:0] shift_q;
        adc_pkg::sample_t      sample;

        // The last bit is still on DOUT, so it joins the sample directly
        assign sample = {shift_q, dout};

        always_ff @(posedge clock or posedge reset)
        begin
                if (reset)
                begin
                        shift_q <= '0;
                end
                else if (tick.rise)
                begin
                        shift_q <= {shift_q[shift_bits-2:0], dout};
                end
        end

        // Slots keep their value until the next scan rewrites them
        always_ff @(posedge clock or posedge reset)
        begin
                if (reset)
                begin
                        readings <= '0;
                end
                else if (tick.last && store.write)
                begin
                        readings[store.chan] <= sample;
                end
        end

endmodule

`default_nettype wire

// File: rtl/command_shifter.sv
// Command path to the ADC DIN pin.
// On cmd_load the channel is packed into an LTC2308 command word, which then
// shifts out MSB first, one bit per SCLK fall, followed by zeros.

`timescale 1ns/1ps
`default_nettype none

module command_shifter (
        input  logic                clock,
        input  logic                reset,
        input  logic                cmd_load,
        input  adc_pkg::chan_t      cmd_chan,
        input  adc_pkg::sclk_tick_t tick,
        output logic                din
);

        localparam int cmd_bits = $bits(adc_pkg::ltc_cmd_t);
        localparam int pad_bits = adc_pkg::FRAME_BITS - cmd_bits;

        adc_pkg::ltc_cmd_t                 cmd;
        logic [adc_pkg::FRAME_BITS-1:0]    shift_q;

        // The part decodes the address as O/S, S1, S0, hence the bit swap
        always_comb
        begin
                cmd.single_ended = 1'b1;
                cmd.odd_sign     = cmd_chan[0];
                cmd.sel1         = cmd_chan[2];
                cmd.sel0         = cmd_chan[1];
                cmd.unipolar     = 1'b1;
                cmd.sleep        = 1'b0;
        end

        always_ff @(posedge clock or posedge reset)
        begin
                if (reset)
                begin
                        shift_q <= '0;
                end
                else if (cmd_load)
                begin
                        shift_q <= {cmd, {pad_bits{1'b0}}};
                end
                else if (tick.fall)
                begin
                        // The ADC samples DIN on the rise, so move on after each fall
                        shift_q <= {shift_q[adc_pkg::FRAME_BITS-2:0], 1'b0};
                end
        end

        assign din = shift_q[adc_pkg::FRAME_BITS-1];

endmodule

`default_nettype wire

// File: rtl/sclk_gen.sv
// SCLK divider for the ADC serial port.
// Runs only while cs_n is low, produces exactly FRAME_BITS rising edges per frame
// and flags each edge one clock ahead through the tick strobes.

`timescale 1ns/1ps
`default_nettype none

module sclk_gen #(
        parameter int t_sclk = 4
) (
        input  logic                clock,
        input  logic                reset,
        input  logic                cs_n,
        output logic                sclk,
        output adc_pkg::sclk_tick_t tick
);

        localparam int half   = t_sclk / 2;
        localparam int cnt_w  = $clog2(half);
        localparam int edge_w = $clog2(adc_pkg::FRAME_BITS + 1);

        localparam logic [cnt_w-1:0] reload = cnt_w'(half - 1);

        logic [cnt_w-1:0]  half_cnt;
        logic [edge_w-1:0] rise_cnt;
        logic              phase_end;
        logic              more_rises;

        assign phase_end  = !cs_n && (half_cnt == '0);
        assign more_rises = rise_cnt < edge_w'(adc_pkg::FRAME_BITS);

        // Once all rises are spent SCLK may still fall, but never rises again
        assign tick.rise = phase_end && !sclk && more_rises;
        assign tick.fall = phase_end && sclk;
        assign tick.last = tick.rise && (rise_cnt == edge_w'(adc_pkg::FRAME_BITS - 1));

        always_ff @(posedge clock or posedge reset)
        begin
                if (reset)
                begin
                        half_cnt <= reload;
                        sclk     <= 1'b0;
                        rise_cnt <= '0;
                end
                else if (cs_n)
                begin
                        // Parked low between frames so the first phase is a full low half
                        half_cnt <= reload;
                        sclk     <= 1'b0;
                        rise_cnt <= '0;
                end
                else
                begin
                        if (phase_end)
                                half_cnt <= reload;
                        else
                                half_cnt <= half_cnt - 1'b1;

                        if (tick.rise)
                        begin
                                sclk     <= 1'b1;
                                rise_cnt <= rise_cnt + 1'b1;
                        end
                        else if (tick.fall)
                        begin
                                sclk <= 1'b0;
                        end
                end
        end

endmodule

`default_nettype wire

// File: rtl/adc_pkg.sv
// Shared types and constants for the LTC2308 scanning controller.
// Every block refers to these by scoped name, for example adc_pkg::sample_t.

`default_nettype none

package adc_pkg;

        // Bits clocked per conversion frame, and the idle gap between frames in SCLK periods
        localparam int FRAME_BITS    = 12;
        localparam int QUIET_PERIODS = 32;

        typedef logic [11:0] sample_t;
        typedef logic [2:0]  chan_t;

        // Bank of readings, slot n holds the latest result of channel n
        typedef sample_t [7:0] readings_t;

        // Command word as shifted out MSB first on DIN
        typedef struct packed {
                logic single_ended;
                logic odd_sign;
                logic sel1;
                logic sel0;
                logic unipolar;
                logic sleep;
        } ltc_cmd_t;

        // One-cycle strobes ahead of SCLK edges
        typedef struct packed {
                logic fall;
                logic rise;
                logic last;
        } sclk_tick_t;

        typedef struct packed {
                logic  write;
                chan_t chan;
        } store_t;

        typedef enum logic [2:0] {
                st_idle,
                st_init,
                st_init_quiet,
                st_frame,
                st_quiet,
                st_done
        } scan_state_e;

endpackage

`default_nettype wire
